// ==== boundary_pkg.sv ====
// Shared definitions for the instruction boundary marker.
// Length codes, offset widths and chunk constants.
`default_nettype none

package boundary_pkg;

  // length code of one byte slot, from the upstream predecoder
  typedef enum logic [1:0] {
    len_2 = 2'd0,
    len_3 = 2'd1,
    len_4 = 2'd2,
    len_6 = 2'd3
  } len_code_e;

  localparam int max_len = 6;                          // longest instruction in bytes
  localparam int spill_width = max_len - 1;            // end marks past the chunk edge
  localparam int offset_width = max_len;               // one-hot start offset, 0 to 5
  localparam int off_bin_width = $clog2(offset_width); // binary offset
  localparam int table_bytes = 8;                      // bytes covered by one end-mark table

  localparam logic [offset_width-1:0] offset_zero = 1; // one-hot offset 0

  // byte count of a length code
  function automatic int unsigned len_of(len_code_e code);
    int unsigned len;
    case (code)
      len_2: len = 2;
      len_3: len = 3;
      len_4: len = 4;
      default: len = max_len;
    endcase
    return len;
  endfunction

endpackage

`default_nettype wire

// ==== boundary_tracker.sv ====
// Registered tracker, holds the carried offset and the pending end mark,
// merges them into the chunk's end mask and counts the instructions.
`timescale 1ns/10ps
`default_nettype none

module boundary_tracker #(
  parameter int chunk_bytes = 8
) (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  logic                                              in_valid,
  input  logic                                              redirect,
  input  logic [boundary_pkg::off_bin_width-1:0]            redirect_offset,
  input  logic [chunk_bytes+boundary_pkg::spill_width-1:0] raw_marks,
  input  logic [boundary_pkg::offset_width-1:0]             next_offset,
  output logic [boundary_pkg::offset_width-1:0]             cur_offset,
  output logic                                              out_valid,
  output logic [chunk_bytes-1:0]                            end_mask,
  output logic [$clog2(chunk_bytes+1)-1:0]                  insn_count,
  output logic                                              spill
);
  import boundary_pkg::*;

  localparam int count_width = $clog2(chunk_bytes + 1);

  logic [offset_width-1:0] offset_q;     // carried offset, one-hot
  logic                    pending_q;    // previous chunk ends inside this one
  logic [offset_width-1:0] redir_onehot;
  logic [chunk_bytes-1:0]  pend_mask;
  logic [chunk_bytes-1:0]  merged;
  logic [count_width-1:0]  merged_count;
  logic                    spill_now;

  always_comb begin
    redir_onehot = '0;
    if (redirect_offset < offset_width) begin // 6 and 7 select nothing
      redir_onehot[redirect_offset] = 1'b1;
    end
  end

  assign cur_offset = redirect ? redir_onehot : offset_q;

  // pending end is the byte just below the carried offset
  always_comb begin
    pend_mask = '0;
    if (pending_q && !redirect) begin
      pend_mask[offset_width-2:0] = offset_q[offset_width-1:1];
    end
  end

  assign merged = raw_marks[chunk_bytes-1:0] | pend_mask;
  assign spill_now = |raw_marks[chunk_bytes +: spill_width]; // ends past the edge

  always_comb begin
    merged_count = '0;
    for (int i = 0; i < chunk_bytes; i++) begin
      merged_count = merged_count + count_width'(merged[i]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      offset_q <= offset_zero;
      pending_q <= 1'b0;
    end else begin
      out_valid <= in_valid;
      if (in_valid) begin
        offset_q <= next_offset;
        pending_q <= spill_now; // spilled end shows up in the next chunk
      end else if (redirect) begin
        offset_q <= redir_onehot;
        pending_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      end_mask <= merged;
      insn_count <= merged_count;
      spill <= spill_now;
    end
  end

endmodule

`default_nettype wire

// ==== chunk_boundary_mark.sv ====
// Chunk boundary marker, applies the start offset to the end-mark tables
// and derives the next chunk's offset. Wider chunks split into two halves.
`timescale 1ns/10ps
`default_nettype none

module chunk_boundary_mark #(
  parameter int chunk_bytes = 8
) (
  input  logic [boundary_pkg::offset_width-1:0]             start_offset,
  input  logic [2*chunk_bytes-1:0]                          sizes,
  output logic [chunk_bytes+boundary_pkg::spill_width-1:0] marks,
  output logic [boundary_pkg::offset_width-1:0]             next_offset
);
  import boundary_pkg::*;

  if (chunk_bytes > table_bytes) begin : g_split
    localparam int half = chunk_bytes / 2;

    logic [half+spill_width-1:0] lo_marks;
    logic [half+spill_width-1:0] hi_marks;
    logic [offset_width-1:0]     mid_offset; // carried from low half to high half

    chunk_boundary_mark #(.chunk_bytes(half)) u_lo (
      .start_offset (start_offset),
      .sizes        (sizes[2*half-1:0]),
      .marks        (lo_marks),
      .next_offset  (mid_offset)
    );

    chunk_boundary_mark #(.chunk_bytes(half)) u_hi (
      .start_offset (mid_offset),
      .sizes        (sizes[2*chunk_bytes-1:2*half]),
      .marks        (hi_marks),
      .next_offset  (next_offset)
    );

    // low half's spilled end lands in the high half
    assign marks = {hi_marks, lo_marks[half-1:0]} |
                   ((chunk_bytes + spill_width)'(lo_marks[half +: spill_width]) << half);
  end else begin : g_leaf
    localparam int mark_width = table_bytes + spill_width;

    logic [2*(table_bytes+spill_width)-1:0] padded;
    wire  [mark_width-1:0]                  tbl_marks [offset_width];
    logic [mark_width-1:0]                  sel_marks;
    logic [offset_width-1:0]                first;
    logic                                   found;

    // slots past the edge read as len_6 so their marks fall off the top
    assign padded = {{spill_width{len_6}}, sizes};

    for (genvar k = 0; k < offset_width; k++) begin : g_tbl
      logic [mark_width-1:0] raw;

      end_mark_table u_tbl (
        .sizes (padded[2*k +: 2*table_bytes]),
        .marks (raw)
      );

      assign tbl_marks[k] = raw << k; // back to chunk positions
    end

    // and-or mux on the one-hot offset
    always_comb begin
      sel_marks = '0;
      for (int k = 0; k < offset_width; k++) begin
        if (start_offset[k]) begin
          sel_marks = sel_marks | tbl_marks[k];
        end
      end
    end

    assign marks = sel_marks;

    // window starts one slot below the edge, so its first bit is the next offset
    first_bit_find #(.width(offset_width)) u_find (
      .vec   (sel_marks[table_bytes-1 +: offset_width]),
      .first (first),
      .found (found)
    );

    assign next_offset = found ? first : offset_zero; // no end found on a bad offset
  end

endmodule

`default_nettype wire

// ==== end_mark_table.sv ====
// End-mark table for one 8-byte chunk walked from slot 0.
// Marks the last byte of every instruction, including the one that spills.
`timescale 1ns/10ps
`default_nettype none

module end_mark_table (
  input  logic [2*boundary_pkg::table_bytes-1:0]                          sizes,
  output logic [boundary_pkg::table_bytes+boundary_pkg::spill_width-1:0] marks
);
  import boundary_pkg::*;

  int unsigned            slot_len [table_bytes]; // byte count per slot
  logic [table_bytes-1:0] reached;                // slots where an instruction starts

  // decode every slot, skipped ones are simply never looked at
  always_comb begin
    for (int p = 0; p < table_bytes; p++) begin
      slot_len[p] = len_of(len_code_e'(sizes[2*p +: 2]));
    end
  end

  // walk the chunk, each instruction start enables the next one
  always_comb begin
    reached = '0;
    marks = '0;
    reached[0] = 1'b1;
    for (int p = 0; p < table_bytes; p++) begin
      if (reached[p]) begin
        marks[p + slot_len[p] - 1] = 1'b1; // last byte, up to slot 12
        if (p + slot_len[p] < table_bytes) begin
          reached[p + slot_len[p]] = 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== first_bit_find.sv ====
// Priority finder, lowest set bit of a vector as a one-hot value
`timescale 1ns/10ps
`default_nettype none

module first_bit_find #(
  parameter int width = 8
) (
  input  logic [width-1:0] vec,
  output logic [width-1:0] first,
  output logic             found
);

  // scan from the top so the lowest set bit is the last one written
  always_comb begin
    first = '0;
    for (int i = width - 1; i >= 0; i--) begin
      if (vec[i]) begin
        first = '0;
        first[i] = 1'b1;
      end
    end
  end

  assign found = |vec; // any bit set

endmodule

`default_nettype wire

// ==== insn_boundary_top.sv ====
// Instruction boundary marker top, chunk marker feeding the offset tracker
`timescale 1ns/10ps
`default_nettype none

module insn_boundary_top #(
  parameter int chunk_bytes = 8
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   in_valid,
  input  logic [2*chunk_bytes-1:0]               sizes,
  input  logic                                   redirect,
  input  logic [boundary_pkg::off_bin_width-1:0] redirect_offset,
  output logic                                   out_valid,
  output logic [chunk_bytes-1:0]                 end_mask,
  output logic [$clog2(chunk_bytes+1)-1:0]       insn_count,
  output logic                                   spill
);
  import boundary_pkg::*;

  logic [offset_width-1:0]            cur_offset;  // tracker to marker
  logic [chunk_bytes+spill_width-1:0] raw_marks;
  logic [offset_width-1:0]            next_offset; // marker back to tracker

  chunk_boundary_mark #(.chunk_bytes(chunk_bytes)) u_mark (
    .start_offset (cur_offset),
    .sizes        (sizes),
    .marks        (raw_marks),
    .next_offset  (next_offset)
  );

  boundary_tracker #(.chunk_bytes(chunk_bytes)) u_track (
    .clk             (clk),
    .rst_n           (rst_n),
    .in_valid        (in_valid),
    .redirect        (redirect),
    .redirect_offset (redirect_offset),
    .raw_marks       (raw_marks),
    .next_offset     (next_offset),
    .cur_offset      (cur_offset),
    .out_valid       (out_valid),
    .end_mask        (end_mask),
    .insn_count      (insn_count),
    .spill           (spill)
  );

endmodule

`default_nettype wire

// ==== sources.f ====
boundary_pkg.sv
first_bit_find.sv
end_mark_table.sv
chunk_boundary_mark.sv
boundary_tracker.sv
insn_boundary_top.sv
tb_insn_boundary.sv

// ==== tb_insn_boundary.sv ====
// Testbench for the instruction boundary marker.
// Table of directed and random chunks, expected values from a reference walk.
`timescale 1ns/10ps
`default_nettype none

module tb_insn_boundary;

  localparam int num_rows = 32;
  localparam int directed_rows = 12;
  localparam int clk_period = 20;
  localparam int watchdog_ns = (num_rows + 20) * clk_period * 4;

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  logic [15:0] sizes;
  logic        redirect;
  logic [2:0]  redirect_offset;
  logic        out_valid;
  logic [7:0]  end_mask;
  logic [3:0]  insn_count;
  logic        spill;

  // stimulus and expected values, one row per cycle
  logic        tv_valid [num_rows];
  logic        tv_redirect [num_rows];
  logic [2:0]  tv_roff [num_rows];
  logic [15:0] tv_sizes [num_rows];
  logic [7:0]  exp_mask [num_rows];
  logic [3:0]  exp_count [num_rows];
  logic        exp_spill [num_rows];

  int          errors = 0;
  int          model_offset = 0; // reference walk state across rows
  bit          model_pending = 0;
  logic [31:0] rng_state = 32'd60;

  insn_boundary_top #(.chunk_bytes(8)) dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .in_valid        (in_valid),
    .sizes           (sizes),
    .redirect        (redirect),
    .redirect_offset (redirect_offset),
    .out_valid       (out_valid),
    .end_mask        (end_mask),
    .insn_count      (insn_count),
    .spill           (spill)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(watchdog_ns);
    $display("run timed out before all rows were checked");
    $display("Test failed");
    $finish;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int code_len(input logic [1:0] code);
    int len;
    case (code)
      2'd0: len = 2;
      2'd1: len = 3;
      2'd2: len = 4;
      default: len = 6;
    endcase
    return len;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic load_row(input int i, input logic v, input logic r,
                          input logic [2:0] off, input logic [15:0] s);
    tv_valid[i] = v;
    tv_redirect[i] = r;
    tv_roff[i] = off;
    tv_sizes[i] = s;
  endtask

  // walk one row from the carried offset, last byte of every instruction
  task automatic model_row(input int i);
    int         p;
    int         len;
    int         last;
    int         next;
    bit         pend;
    logic [7:0] mask;
    p = tv_redirect[i] ? int'(tv_roff[i]) : model_offset;
    pend = tv_redirect[i] ? 1'b0 : model_pending;
    if (!tv_valid[i]) begin
      model_offset = p; // redirect alone only moves the offset
      model_pending = pend;
    end else begin
      mask = '0;
      if (pend && p > 0) mask[p-1] = 1'b1; // end spilled from previous chunk
      next = -1;
      while (next < 0) begin
        len = code_len(tv_sizes[i][2*p +: 2]);
        last = p + len - 1;
        if (last < 8) mask[last] = 1'b1;
        if (last >= 7) next = p + len - 8;
        else p = p + len;
      end
      exp_mask[i] = mask;
      exp_count[i] = 4'($countones(mask));
      exp_spill[i] = (next > 0);
      model_offset = next;
      model_pending = (next > 0);
    end
  endtask

  task automatic build_table();
    logic [31:0] r;
    load_row(0, 1'b1, 1'b0, 3'd0, 16'h0000);  // all len_2
    load_row(1, 1'b1, 1'b0, 3'd0, 16'hC001);  // len_6 at slot 7
    load_row(2, 1'b1, 1'b0, 3'd0, 16'h0000);  // starts at 5, pending end
    load_row(3, 1'b1, 1'b1, 3'd3, 16'hFFFF);
    load_row(4, 1'b0, 1'b1, 3'd5, 16'h0000);  // redirect without chunk
    load_row(5, 1'b1, 1'b0, 3'd0, 16'h5555);
    load_row(6, 1'b1, 1'b1, 3'd0, 16'hAAAA);
    load_row(7, 1'b0, 1'b1, 3'd1, 16'h0000);
    load_row(8, 1'b1, 1'b0, 3'd0, 16'h1B6C);
    load_row(9, 1'b1, 1'b1, 3'd2, 16'h3020);  // spills to offset 4
    load_row(10, 1'b0, 1'b1, 3'd4, 16'h0000); // drops the pending end
    load_row(11, 1'b1, 1'b0, 3'd0, 16'h4E93);
    for (int i = directed_rows; i < num_rows; i++) begin
      rng_state = xorshift(rng_state);
      r = rng_state;
      load_row(i, (r[31:29] != 3'd0) | r[25], r[31:29] == 3'd0,
               3'(r[28:26] % 6), r[15:0]);
    end
    for (int i = 0; i < num_rows; i++) model_row(i);
  endtask

  task automatic check_row(input int i);
    check_value("out_valid", 32'(out_valid), 32'(tv_valid[i]));
    if (tv_valid[i]) begin
      check_value($sformatf("end_mask row %0d", i), 32'(end_mask), 32'(exp_mask[i]));
      check_value($sformatf("insn_count row %0d", i), 32'(insn_count), 32'(exp_count[i]));
      check_value($sformatf("spill row %0d", i), 32'(spill), 32'(exp_spill[i]));
    end
  endtask

  initial begin
    rst_n = 1'b0;
    in_valid = 1'b0;
    sizes = '0;
    redirect = 1'b0;
    redirect_offset = '0;
    build_table();
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (3) begin // idle, nothing may come out
      @(negedge clk);
      check_value("out_valid idle", 32'(out_valid), 32'd0);
    end
    for (int i = 0; i <= num_rows; i++) begin
      @(negedge clk);
      if (i > 0) check_row(i - 1); // result of the row driven one cycle ago
      in_valid = (i < num_rows) ? tv_valid[i] : 1'b0;
      redirect = (i < num_rows) ? tv_redirect[i] : 1'b0;
      redirect_offset = (i < num_rows) ? tv_roff[i] : 3'd0;
      sizes = (i < num_rows) ? tv_sizes[i] : 16'h0000;
    end
    @(negedge clk);
    check_value("out_valid after last row", 32'(out_valid), 32'd0);
    $display("checks done with %0d errors", errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
